//--- src/telemetry_pkg.sv
package telemetry_pkg;

        // One byte on the wire
        typedef logic [7:0] byte_t;

        // Payload bits carried in each data byte, bit 7 stays clear
        localparam int PAYLOAD_BITS = 7;

        typedef logic [PAYLOAD_BITS-1:0] payload_t;

        // Input sample, two payloads
        typedef logic [2*PAYLOAD_BITS-1:0] sample_t;

        // Command value, three payloads
        typedef logic [3*PAYLOAD_BITS-1:0] value_t;

        // Received byte with its strobe
        typedef struct packed {
                logic  valid;
                byte_t data;
        } rx_byte_t;

        // Header of the command for channel 0
        localparam int HEADER_BASE = 150;

        // Flag byte for the upper half of input 0
        localparam int FLAG_BASE = 200;

endpackage

//--- src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
        import telemetry_pkg::*;
#(
        parameter int CLKS_PER_BIT = 16
)
(
        input  logic     clk,
        input  logic     rst_n,
        input  logic     rx,
        output rx_byte_t rx_byte
);

        localparam int CW = $clog2(CLKS_PER_BIT);

        typedef enum logic [1:0] {
                S_IDLE,
                S_START,
                S_DATA,
                S_STOP
        } rx_state_t;

        rx_state_t      state;
        logic           rx_meta;
        logic           rx_sync;
        logic [CW-1:0]  cnt;
        logic [2:0]     bit_cnt;
        logic           valid_q;
        byte_t          shreg;

        // Two-flop synchronizer, idles high
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        rx_meta <= 1'b1;
                        rx_sync <= 1'b1;
                end
                else
                begin
                        rx_meta <= rx;
                        rx_sync <= rx_meta;
                end
        end

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        state   <= S_IDLE;
                        cnt     <= '0;
                        bit_cnt <= '0;
                        valid_q <= 1'b0;
                end
                else
                begin
                        valid_q <= 1'b0;
                        cnt     <= cnt + 1'b1;
                        case (state)
                        S_IDLE:
                        begin
                                cnt <= '0;
                                if (!rx_sync)
                                        state <= S_START;
                        end
                        S_START:
                        begin
                                // Half a bit in, recheck for a glitch
                                if (cnt == CW'(CLKS_PER_BIT / 2 - 1))
                                begin
                                        cnt     <= '0;
                                        bit_cnt <= '0;
                                        state   <= rx_sync ? S_IDLE : S_DATA;
                                end
                        end
                        S_DATA:
                        begin
                                if (cnt == CW'(CLKS_PER_BIT - 1))
                                begin
                                        cnt     <= '0;
                                        bit_cnt <= bit_cnt + 1'b1;
                                        if (bit_cnt == 3'd7)
                                                state <= S_STOP;
                                end
                        end
                        default:
                        begin
                                if (cnt == CW'(CLKS_PER_BIT - 1))
                                begin
                                        // Framing error drops the byte
                                        valid_q <= rx_sync;
                                        state   <= S_IDLE;
                                end
                        end
                        endcase
                end
        end

        // LSB first
        always_ff @(posedge clk)
        begin
                if (state == S_DATA && cnt == CW'(CLKS_PER_BIT - 1))
                        shreg <= {rx_sync, shreg[7:1]};
        end

        assign rx_byte.valid = valid_q;
        assign rx_byte.data  = shreg;

        a_single_valid: assert property (@(posedge clk) disable iff (!rst_n)
                valid_q |=> !valid_q);

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
        import telemetry_pkg::*;
#(
        parameter int CLKS_PER_BIT = 16
)
(
        input  logic  clk,
        input  logic  rst_n,
        input  byte_t tx_byte,
        output logic  tx,
        output logic  send
);

        localparam int CW = $clog2(CLKS_PER_BIT);

        logic [CW-1:0] cnt;
        logic [3:0]    bit_cnt;
        logic [9:0]    shreg;
        logic          bit_end;
        logic          load;

        assign bit_end = (cnt == CW'(CLKS_PER_BIT - 1));

        // End of the stop bit, next frame starts
        assign load = bit_end && (bit_cnt == 4'd9);

        // Reset state sits at a frame boundary so the first byte leaves at once
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        cnt     <= CW'(CLKS_PER_BIT - 1);
                        bit_cnt <= 4'd9;
                        shreg   <= '1;
                        send    <= 1'b0;
                end
                else
                begin
                        send <= load;
                        if (bit_end)
                        begin
                                cnt <= '0;
                                if (load)
                                begin
                                        // Stop, data, start
                                        shreg   <= {1'b1, tx_byte, 1'b0};
                                        bit_cnt <= '0;
                                end
                                else
                                begin
                                        shreg   <= {1'b1, shreg[9:1]};
                                        bit_cnt <= bit_cnt + 1'b1;
                                end
                        end
                        else
                        begin
                                cnt <= cnt + 1'b1;
                        end
                end
        end

        assign tx = shreg[0];

        a_start_with_send: assert property (@(posedge clk) disable iff (!rst_n)
                send |-> !tx);

endmodule

//--- src/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder
        import telemetry_pkg::*;
#(
        parameter int NUM_OUT = 6
)
(
        input  logic     clk,
        input  logic     rst_n,
        input  rx_byte_t rx_byte,
        output value_t   values [NUM_OUT],
        output logic     data_ready
);

        localparam int    IW     = (NUM_OUT > 1) ? $clog2(NUM_OUT) : 1;
        localparam byte_t HDR_LO = byte_t'(HEADER_BASE);
        localparam byte_t HDR_HI = byte_t'(HEADER_BASE + NUM_OUT);

        typedef enum logic [1:0] {
                S_HUNT,
                S_P1,
                S_P2,
                S_P3
        } cmd_state_t;

        cmd_state_t     state;
        logic [IW-1:0]  idx;
        payload_t       part1;
        payload_t       part2;
        byte_t          hdr_off;
        logic           hdr_ok;

        assign hdr_off = rx_byte.data - HDR_LO;
        assign hdr_ok  = (rx_byte.data >= HDR_LO) && (rx_byte.data < HDR_HI);

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        state      <= S_HUNT;
                        idx        <= '0;
                        data_ready <= 1'b0;
                        for (int i = 0; i < NUM_OUT; i++)
                                values[i] <= '0;
                end
                else
                begin
                        data_ready <= 1'b0;
                        if (rx_byte.valid)
                        begin
                                case (state)
                                S_HUNT:
                                begin
                                        // Anything but a known header is skipped
                                        if (hdr_ok)
                                        begin
                                                idx   <= hdr_off[IW-1:0];
                                                state <= S_P1;
                                        end
                                end
                                S_P1:
                                        state <= S_P2;
                                S_P2:
                                        state <= S_P3;
                                default:
                                begin
                                        values[idx] <= {part1, part2,
                                                        rx_byte.data[PAYLOAD_BITS-1:0]};
                                        data_ready  <= 1'b1;
                                        state       <= S_HUNT;
                                end
                                endcase
                        end
                end
        end

        // Partial payloads, most significant first
        always_ff @(posedge clk)
        begin
                if (rx_byte.valid && state == S_P1)
                        part1 <= rx_byte.data[PAYLOAD_BITS-1:0];
                if (rx_byte.valid && state == S_P2)
                        part2 <= rx_byte.data[PAYLOAD_BITS-1:0];
        end

        a_idx_in_range: assert property (@(posedge clk) disable iff (!rst_n)
                (rx_byte.valid && state == S_P3) |-> (int'(idx) < NUM_OUT));

endmodule

//--- src/frame_scanner.sv
`timescale 1ns/1ps

module frame_scanner
        import telemetry_pkg::*;
#(
        parameter int NUM_IN = 4
)
(
        input  logic    clk,
        input  logic    rst_n,
        input  sample_t samples [NUM_IN],
        input  logic    send,
        output byte_t   tx_byte
);

        localparam int CHW = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

        logic [CHW-1:0] ch;
        logic [1:0]     phase;
        sample_t        snap [NUM_IN];
        sample_t        cur;
        logic           snap_en;

        // Flag of channel 0 going out starts a new frame
        assign snap_en = send && (phase == 2'd0) && (ch == '0);

        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        ch    <= '0;
                        phase <= 2'd0;
                end
                else if (send)
                begin
                        phase <= phase + 1'b1;
                        if (phase == 2'd3)
                        begin
                                if (ch == CHW'(NUM_IN - 1))
                                        ch <= '0;
                                else
                                        ch <= ch + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk)
        begin
                if (snap_en)
                        snap <= samples;
        end

        assign cur = snap[ch];

        // Flag M, upper half, flag L, lower half
        always_comb
        begin
                case (phase)
                2'd0:
                        tx_byte = byte_t'(FLAG_BASE + 2 * int'(ch));
                2'd1:
                        tx_byte = {1'b0, cur[2*PAYLOAD_BITS-1:PAYLOAD_BITS]};
                2'd2:
                        tx_byte = byte_t'(FLAG_BASE + 2 * int'(ch) + 1);
                default:
                        tx_byte = {1'b0, cur[PAYLOAD_BITS-1:0]};
                endcase
        end

        a_payload_msb_clear: assert property (@(posedge clk) disable iff (!rst_n)
                (send && phase[0]) |-> !tx_byte[7]);

endmodule

//--- src/telemetry_link.sv
`timescale 1ns/1ps

module telemetry_link
        import telemetry_pkg::*;
#(
        parameter int CLKS_PER_BIT = 16,
        parameter int NUM_IN       = 4,
        parameter int NUM_OUT      = 6
)
(
        input  logic    clk,
        input  logic    rst_n,
        input  logic    rx,
        input  sample_t samples [NUM_IN],
        output logic    tx,
        output logic    send,
        output value_t  values [NUM_OUT],
        output logic    data_ready
);

        rx_byte_t rx_byte;
        byte_t    tx_byte;

        // Command path
        uart_rx #(
                .CLKS_PER_BIT (CLKS_PER_BIT)
        ) rx0 (
                .clk     (clk),
                .rst_n   (rst_n),
                .rx      (rx),
                .rx_byte (rx_byte)
        );

        cmd_decoder #(
                .NUM_OUT (NUM_OUT)
        ) dec0 (
                .clk        (clk),
                .rst_n      (rst_n),
                .rx_byte    (rx_byte),
                .values     (values),
                .data_ready (data_ready)
        );

        // Sample stream
        frame_scanner #(
                .NUM_IN (NUM_IN)
        ) scan0 (
                .clk     (clk),
                .rst_n   (rst_n),
                .samples (samples),
                .send    (send),
                .tx_byte (tx_byte)
        );

        uart_tx #(
                .CLKS_PER_BIT (CLKS_PER_BIT)
        ) tx0 (
                .clk     (clk),
                .rst_n   (rst_n),
                .tx_byte (tx_byte),
                .tx      (tx),
                .send    (send)
        );

endmodule

//--- include/tb_uart_tasks.svh
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// Xorshift step, 32-bit state
function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
endfunction

// Called right after a falling edge, rx only moves there
task automatic drive_rx_byte(input byte_t b);
        rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++)
        begin
                rx = b[i];
                repeat (CLKS_PER_BIT) @(negedge clk);
        end
        rx = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk);
endtask

// Entered on the first falling edge that sees the start bit
task automatic capture_tx_byte(output byte_t b, output logic ok);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        ok = !tx;
        for (int i = 0; i < 8; i++)
        begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                b[i] = tx;
        end
        // Middle of the stop bit
        repeat (CLKS_PER_BIT) @(negedge clk);
        ok = ok && tx;
endtask

`endif

//--- test/tb_telemetry_link.sv
`timescale 1ns/1ps

module tb_telemetry_link
        import telemetry_pkg::*;
();

        localparam int  CLKS_PER_BIT   = 16;
        localparam int  NUM_IN         = 4;
        localparam int  NUM_OUT        = 6;
        localparam int  RESET_CYCLES   = 16;
        localparam int  FRAME_BYTES    = 4 * NUM_IN;
        localparam int  BYTE_CYCLES    = 10 * CLKS_PER_BIT;
        localparam int  TIMEOUT_CYCLES = 60000;
        localparam time SEND_GAP       = BYTE_CYCLES * 100;

        logic        clk;
        logic        rst_n;
        logic        rx;
        sample_t     samples [NUM_IN];
        logic        tx;
        logic        send;
        value_t      values [NUM_OUT];
        logic        data_ready;

        logic [31:0] rng = 32'd42597;
        value_t      exp_values [NUM_OUT];
        sample_t     snap [NUM_IN];
        logic [8:0]  exp_q [$];
        int          errors = 0;
        int          send_errors = 0;
        int          ready_count = 0;
        int          expected_ready = 0;
        int          frame_count = 0;
        int          bytes_checked = 0;
        int          pos = 0;
        int          tests_passed = 0;
        int          tests_failed = 0;

        `include "tb_uart_tasks.svh"

        telemetry_link #(
                .CLKS_PER_BIT (CLKS_PER_BIT),
                .NUM_IN       (NUM_IN),
                .NUM_OUT      (NUM_OUT)
        ) dut0 (
                .clk        (clk),
                .rst_n      (rst_n),
                .rx         (rx),
                .samples    (samples),
                .tx         (tx),
                .send       (send),
                .values     (values),
                .data_ready (data_ready)
        );

        initial
        begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        function automatic logic [31:0] next_random();
                rng = xorshift32(rng);
                return rng;
        endfunction

        task automatic randomize_samples();
                for (int i = 0; i < NUM_IN; i++)
                        samples[i] = sample_t'(next_random());
        endtask

        task automatic check_bit(input string name, input logic got, input logic want);
                assert (got === want) else
                begin
                        errors++;
                        $display("Fail at %0t: %s got %b expected %b", $time, name, got, want);
                end
        endtask

        task automatic check_values();
                for (int i = 0; i < NUM_OUT; i++)
                        assert (values[i] === exp_values[i]) else
                        begin
                                errors++;
                                $display("Fail at %0t: values[%0d] got %h expected %h",
                                         $time, i, values[i], exp_values[i]);
                        end
        endtask

        task automatic check_ready_count();
                for (int n = 0; n < 2 * CLKS_PER_BIT && ready_count < expected_ready; n++)
                        @(negedge clk);
                assert (ready_count == expected_ready) else
                begin
                        errors++;
                        $display("Fail at %0t: data_ready pulses got %0d expected %0d",
                                 $time, ready_count, expected_ready);
                end
        endtask

        task automatic write_command(input int k, input value_t v);
                logic [31:0] r;
                r = next_random();
                drive_rx_byte(byte_t'(HEADER_BASE + k));
                // Bit 7 of each payload byte is noise
                drive_rx_byte({r[0], v[20:14]});
                drive_rx_byte({r[1], v[13:7]});
                drive_rx_byte({r[2], v[6:0]});
                expected_ready++;
                exp_values[k] = v;
                check_ready_count();
                check_values();
        endtask

        task automatic wait_frames(input int n);
                int target;
                int waited;
                target = frame_count + n;
                waited = 0;
                while (frame_count < target && waited < (n + 1) * FRAME_BYTES * BYTE_CYCLES)
                begin
                        @(negedge clk);
                        waited++;
                end
                assert (frame_count >= target) else
                begin
                        errors++;
                        $display("Stream stalled at frame %0d before frame %0d",
                                 frame_count, target);
                end
                // Last byte of the frame still decoding
                repeat (BYTE_CYCLES) @(negedge clk);
        endtask

        task automatic report_test(input string name, input int errs_before);
                if (errors == errs_before)
                begin
                        tests_passed++;
                        $display("Test %s: passed", name);
                end
                else
                begin
                        tests_failed++;
                        $display("Test %s: failed with %0d errors", name, errors - errs_before);
                end
        endtask

        // Top bit marks a payload byte
        function automatic logic [8:0] expected_stream_byte(input int p);
                int ch;
                ch = p / 4;
                case (p % 4)
                0:
                        return {1'b0, byte_t'(FLAG_BASE + 2 * ch)};
                1:
                        return {2'b10, snap[ch][13:7]};
                2:
                        return {1'b0, byte_t'(FLAG_BASE + 2 * ch + 1)};
                default:
                        return {2'b10, snap[ch][6:0]};
                endcase
        endfunction

        a_send_at_start: assert property (@(posedge clk) disable iff (!rst_n)
                send |-> !tx && $past(tx)) else
        begin
                errors++;
                send_errors++;
                $display("Send pulse at %0t did not line up with a start bit on tx", $time);
        end

        a_ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                data_ready |=> !data_ready) else
        begin
                errors++;
                $display("data_ready stayed high longer than one cycle at %0t", $time);
        end

        always @(negedge clk)
        begin
                if (data_ready)
                        ready_count++;
        end

        // Send pulses, snapshot model and expected stream
        initial
        begin
                time  last_send;
                logic have_last;
                have_last = 1'b0;
                last_send = 0;
                forever
                begin
                        @(negedge clk);
                        if (rst_n && send)
                        begin
                                assert (!have_last || $time - last_send == SEND_GAP) else
                                begin
                                        errors++;
                                        send_errors++;
                                        $display("Fail at %0t: send interval got %0t expected %0t",
                                                 $time, $time - last_send, SEND_GAP);
                                end
                                last_send = $time;
                                have_last = 1'b1;
                                // DUT latches on the edge that ends the pulse
                                @(posedge clk);
                                if (pos == 0)
                                begin
                                        snap = samples;
                                        frame_count++;
                                end
                                exp_q.push_back(expected_stream_byte(pos));
                                pos = (pos + 1) % FRAME_BYTES;
                        end
                end
        end

        // tx decoder
        initial
        begin
                byte_t      b;
                logic       ok;
                logic [8:0] e;
                forever
                begin
                        @(negedge clk);
                        if (rst_n && !tx)
                        begin
                                capture_tx_byte(b, ok);
                                if (!ok)
                                begin
                                        errors++;
                                        $display("tx byte ending at %0t had a bad start or stop bit",
                                                 $time);
                                end
                                if (exp_q.size() == 0)
                                begin
                                        errors++;
                                        $display("tx carried a byte at %0t with no send pulse",
                                                 $time);
                                end
                                else
                                begin
                                        e = exp_q.pop_front();
                                        assert (b === e[7:0]) else
                                        begin
                                                errors++;
                                                $display("Fail at %0t: tx byte got %h expected %h",
                                                         $time, b, e[7:0]);
                                        end
                                        check_bit("tx payload bit 7", b[7] & e[8], 1'b0);
                                        bytes_checked++;
                                end
                        end
                end
        end

        initial
        begin
                int          cycles;
                cycles = 0;
                while (cycles < TIMEOUT_CYCLES)
                begin
                        @(posedge clk);
                        cycles++;
                end
                $display("Timeout after %0d cycles, the tests did not finish", cycles);
                $display("Test failures found");
                $finish;
        end

        initial
        begin
                int          errs;
                int          k;
                int          n;
                int          c0;
                logic [31:0] r;
                byte_t       bad;
                rst_n = 1'b0;
                rx    = 1'b1;
                for (int i = 0; i < NUM_OUT; i++)
                        exp_values[i] = '0;
                randomize_samples();

                errs = errors;
                for (int c = 0; c < RESET_CYCLES; c++)
                begin
                        @(negedge clk);
                        // Reset lands on the first rising edge
                        if (c > 0)
                        begin
                                check_bit("tx", tx, 1'b1);
                                check_bit("data_ready", data_ready, 1'b0);
                                check_values();
                        end
                end
                rst_n = 1'b1;
                @(negedge clk);
                check_bit("data_ready", data_ready, 1'b0);
                check_values();
                report_test("reset state", errs);

                errs = errors;
                repeat (20)
                begin
                        k = int'(next_random() % NUM_OUT);
                        write_command(k, value_t'(next_random()));
                end
                report_test("command write", errs);

                errs = errors;
                repeat (4)
                begin
                        r = next_random();
                        if (r[31])
                                bad = byte_t'(r % HEADER_BASE);
                        else
                                bad = byte_t'(HEADER_BASE + NUM_OUT
                                              + r % (256 - HEADER_BASE - NUM_OUT));
                        drive_rx_byte(bad);
                        // Full command body, a wrongly taken header would store it
                        drive_rx_byte({1'b0, r[14:8]});
                        drive_rx_byte({1'b0, r[21:15]});
                        drive_rx_byte({1'b0, r[28:22]});
                        repeat (2 * CLKS_PER_BIT) @(negedge clk);
                        check_ready_count();
                        check_values();
                        k = int'(next_random() % NUM_OUT);
                        write_command(k, value_t'(next_random()));
                end
                report_test("invalid header", errs);

                errs = errors;
                c0 = bytes_checked;
                randomize_samples();
                wait_frames(3);
                assert (bytes_checked - c0 >= 2 * FRAME_BYTES) else
                begin
                        errors++;
                        $display("Stream checker saw only %0d bytes", bytes_checked - c0);
                end
                report_test("stream format", errs);

                errs = errors;
                n = 0;
                while (pos != FRAME_BYTES / 2 && n < FRAME_BYTES * BYTE_CYCLES)
                begin
                        @(negedge clk);
                        n++;
                end
                check_bit("mid-frame reached", pos == FRAME_BYTES / 2, 1'b1);
                randomize_samples();
                wait_frames(2);
                report_test("snapshot freeze", errs);

                errs = errors;
                repeat (4 * BYTE_CYCLES) @(negedge clk);
                assert (send_errors == 0) else
                begin
                        errors++;
                        $display("%0d send pulses were off cadence or off a start bit",
                                 send_errors);
                end
                report_test("send cadence", errs);

                $display("Tests passed: %0d, failed: %0d, errors: %0d",
                         tests_passed, tests_failed, errors);
                if (errors == 0)
                        $display("All tests passed!");
                else
                        $display("Test failures found");
                $finish;
        end

endmodule

//--- filelist.f
+incdir+include
src/telemetry_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_decoder.sv
src/frame_scanner.sv
src/telemetry_link.sv
test/tb_telemetry_link.sv

//--- run.sh
#!/bin/sh
# Build and run the telemetry link testbench with Verilator
cd "$(dirname "$0")" \
        && verilator --binary --timing --assert --timescale 1ns/1ps \
                -f filelist.f --top-module tb_telemetry_link -o sim_tb \
        && out="$(./obj_dir/sim_tb)" \
        && printf '%s\n' "$out" \
        && printf '%s\n' "$out" | grep -qF "All tests passed!" \
        && echo "PASS" \
        || { echo "FAIL"; exit 1; }
